//--- common/noc_pkg.sv
// NoC router shared types, direction encodings and the XY look-ahead next-hop rule

package noc_pkg;

  ////////////////////////////////////////////////////////////
  // Basic widths
  ////////////////////////////////////////////////////////////

  // Number of router ports, four mesh links plus local
  localparam int num_ports = 5;

  // One mesh coordinate, 8x8 mesh at most
  typedef logic [2:0] coord_t;

  // Router position or packet destination
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_t;

  // One-hot port direction
  typedef logic [4:0] dir_t;

  // Flit body and message type
  typedef logic [31:0] data_t;
  typedef logic [3:0] msg_t;

  // Port indexes, also the bit position in dir_t
  typedef enum logic [2:0] {
    north_port = 3'd0,
    south_port = 3'd1,
    west_port  = 3'd2,
    east_port  = 3'd3,
    local_port = 3'd4
  } port_idx_t;

  // One-hot direction constants
  localparam dir_t go_north = 5'b00001;
  localparam dir_t go_south = 5'b00010;
  localparam dir_t go_west  = 5'b00100;
  localparam dir_t go_east  = 5'b01000;
  localparam dir_t go_local = 5'b10000;

  ////////////////////////////////////////////////////////////
  // Link word and header view
  ////////////////////////////////////////////////////////////

  // The 34-bit word carried on every link
  typedef struct packed {
    logic  head;
    logic  tail;
    data_t body;
  } flit_t;

  // Unused header bits between message type and routing field
  localparam int hdr_pad_w = $bits(data_t) - 2 * $bits(xy_t) - $bits(msg_t) - $bits(dir_t);

  // Body of a head flit, routing field in the low bits
  typedef struct packed {
    xy_t                  source;
    xy_t                  destination;
    msg_t                 message;
    logic [hdr_pad_w-1:0] pad;
    dir_t                 routing;
  } header_t;

  // Output forwarding FSM
  typedef enum logic [1:0] {
    reserve_port  = 2'd0,
    head_flit     = 2'd1,
    payload_flits = 2'd2
  } fwd_state_t;

  ////////////////////////////////////////////////////////////
  // XY look-ahead routing
  ////////////////////////////////////////////////////////////

  // Port the head must take at the neighbour reached through out_dir
  function automatic dir_t next_hop(xy_t position, dir_t out_dir, xy_t destination,
                                    dir_t routing);
    xy_t  nxt;
    dir_t result;
    nxt = position;
    // Step one hop in the chosen direction
    case (out_dir)
      go_north: nxt.y = position.y - 3'd1;
      go_south: nxt.y = position.y + 3'd1;
      go_west:  nxt.x = position.x - 3'd1;
      go_east:  nxt.x = position.x + 3'd1;
      default:  nxt = position;
    endcase
    // X first, then Y, then eject
    if (out_dir == go_local) begin
      result = routing;
    end else if (destination.x > nxt.x) begin
      result = go_east;
    end else if (destination.x < nxt.x) begin
      result = go_west;
    end else if (destination.y > nxt.y) begin
      result = go_south;
    end else if (destination.y < nxt.y) begin
      result = go_north;
    end else begin
      result = go_local;
    end
    return result;
  endfunction

endpackage

//--- rtl/router_fifo.sv
// Input flit queue, circular buffer with a bypass path for the empty queue
`timescale 1ns/1ps

module router_fifo import noc_pkg::*; #(
  parameter int FifoDepth = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  wr_i,
  input  flit_t data_i,
  input  logic  rd_i,
  output flit_t data_o,
  output logic  empty_o,
  output logic  full_o
);

  localparam int AddrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntW  = $clog2(FifoDepth + 1);

  flit_t            mem [FifoDepth];
  logic [AddrW-1:0] wr_ptr;
  logic [AddrW-1:0] rd_ptr;
  logic [CntW-1:0]  count;
  logic             push;
  logic             pop;
  logic             pass;

  assign empty_o = (count == '0);
  assign full_o  = (count == CntW'(FifoDepth));

  // Empty queue read in the same cycle as a write, flit goes straight through
  assign pass = empty_o & wr_i & rd_i;
  // Writes to a full queue are dropped
  assign push = wr_i & ~full_o & ~pass;
  assign pop  = rd_i & ~empty_o;

  // Front of queue, or the incoming flit when nothing is stored
  assign data_o = empty_o ? data_i : mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // Wrap explicitly, depth need not be a power of two
        if (wr_ptr == AddrW'(FifoDepth - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == AddrW'(FifoDepth - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- input_unit/input_port.sv
// Router input channel, flit queue plus the routing request held for the current worm
`timescale 1ns/1ps

module input_port import noc_pkg::*; #(
  parameter int FifoDepth = 4
) (
  input  logic  clk,
  input  logic  rst,
  // Link side
  input  flit_t flit_i,
  input  logic  void_i,
  output logic  stop_o,
  // Crossbar side
  input  logic  rd_i,
  output flit_t head_o,
  output logic  valid_o,
  output dir_t  req_o
);

  logic    fifo_empty;
  logic    fifo_full;
  logic    valid_head;
  header_t hdr;
  dir_t    held_req;

  ////////////////////////////////////////////////////////////
  // Flit queue
  ////////////////////////////////////////////////////////////

  // Every non-void flit is offered to the queue
  router_fifo #(
    .FifoDepth(FifoDepth)
  ) u_fifo (
    .clk    (clk),
    .rst    (rst),
    .wr_i   (~void_i),
    .data_i (flit_i),
    .rd_i   (rd_i),
    .data_o (head_o),
    .empty_o(fifo_empty),
    .full_o (fifo_full)
  );

  // Back-pressure to the upstream sender
  assign stop_o = fifo_full;

  // Front is real when stored, or when a flit arrives on the bypass path
  assign valid_o = ~fifo_empty | ~void_i;

  ////////////////////////////////////////////////////////////
  // Routing request
  ////////////////////////////////////////////////////////////

  assign hdr        = header_t'(head_o.body);
  assign valid_head = valid_o & head_o.head;

  // Keep the head's request for body and tail flits
  always_ff @(posedge clk) begin
    if (rst) begin
      held_req <= '0;
    end else begin
      if (valid_o && head_o.tail) begin
        // Worm ends here, single-flit packets included
        held_req <= '0;
      end else if (valid_head) begin
        held_req <= hdr.routing;
      end
    end
  end

  // Live routing field while the head sits at the front
  assign req_o = valid_head ? hdr.routing : held_req;

endmodule

//--- output_unit/rr_arbiter.sv
// Round-robin arbiter over the four inputs that may compete for one output
`timescale 1ns/1ps

module rr_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] req_i,
  input  logic       hold_i,
  output logic [3:0] grant_o,
  output logic       grant_valid_o
);

  // Index of the input with the highest priority
  logic [1:0] prio_q;
  logic [1:0] cand;
  logic [1:0] win_idx;

  ////////////////////////////////////////////////////////////
  // Grant selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    win_idx       = prio_q;
    grant_valid_o = 1'b0;
    cand          = prio_q;
    // Scan from the farthest offset down, so the nearest requester wins
    for (int k = 3; k >= 0; k--) begin
      cand = prio_q + 2'(k);
      if (req_i[cand]) begin
        win_idx       = cand;
        grant_valid_o = 1'b1;
      end
    end
    grant_o = grant_valid_o ? (4'b0001 << win_idx) : 4'b0000;
  end

  ////////////////////////////////////////////////////////////
  // Priority pointer
  ////////////////////////////////////////////////////////////

  // Move past the winner only when its grant is taken
  // Priority stays put while a worm is in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      prio_q <= '0;
    end else if (grant_valid_o && !hold_i) begin
      prio_q <= win_idx + 2'd1;
    end
  end

endmodule

//--- output_unit/output_port.sv
// Router output channel with arbitration, forwarding FSM, look-ahead rewrite and output register
`timescale 1ns/1ps

module output_port import noc_pkg::*; #(
  parameter port_idx_t OutDir = local_port
) (
  input  logic                        clk,
  input  logic                        rst,
  input  xy_t                         position_i,
  // Fronts of all input queues
  input  flit_t [num_ports-1:0]       heads_i,
  input  logic  [num_ports-1:0]       valids_i,
  input  dir_t  [num_ports-1:0]       reqs_i,
  // Read strobe back to the inputs
  output logic  [num_ports-1:0]       rd_o,
  // Link side
  input  logic                        stop_i,
  output flit_t                       flit_o,
  output logic                        void_o
);

  // This port as a one-hot direction
  localparam dir_t OutMask = dir_t'(1) << OutDir;

  fwd_state_t           state_q;
  fwd_state_t           state_d;
  logic [3:0]           arb_req;
  logic [3:0]           arb_grant;
  logic                 arb_valid;
  logic                 arb_hold;
  logic [num_ports-1:0] grant_full;
  logic [num_ports-1:0] gnt_q;
  flit_t                sel_flit;
  logic                 sel_valid;
  logic                 fwd;
  header_t              hdr;
  flit_t                out_flit;
  flit_t                flit_q;
  logic                 void_q;

  ////////////////////////////////////////////////////////////
  // Request column and arbitration
  ////////////////////////////////////////////////////////////

  // Four arbiter slots, own direction skipped so packets never turn back
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      if (k < int'(OutDir)) begin
        arb_req[k] = valids_i[k] & reqs_i[k][OutDir];
      end else begin
        arb_req[k] = valids_i[k+1] & reqs_i[k+1][OutDir];
      end
    end
  end

  // Pointer frozen unless a grant is taken this cycle
  assign arb_hold = (state_q != reserve_port) | stop_i;

  rr_arbiter u_arb (
    .clk          (clk),
    .rst          (rst),
    .req_i        (arb_req),
    .hold_i       (arb_hold),
    .grant_o      (arb_grant),
    .grant_valid_o(arb_valid)
  );

  // Back to five input positions
  always_comb begin
    grant_full = '0;
    for (int j = 0; j < num_ports; j++) begin
      if (j < int'(OutDir)) begin
        grant_full[j] = arb_grant[j];
      end else if (j > int'(OutDir)) begin
        grant_full[j] = arb_grant[j-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Crossbar mux and look-ahead
  ////////////////////////////////////////////////////////////

  always_comb begin
    sel_flit  = '0;
    sel_valid = 1'b0;
    for (int j = 0; j < num_ports; j++) begin
      if (gnt_q[j]) begin
        sel_flit  = heads_i[j];
        sel_valid = valids_i[j];
      end
    end
  end

  // Head flits get the routing field for the next router
  always_comb begin
    hdr      = header_t'(sel_flit.body);
    out_flit = sel_flit;
    if (sel_flit.head) begin
      hdr.routing   = next_hop(position_i, OutMask, hdr.destination, hdr.routing);
      out_flit.body = data_t'(hdr);
    end
  end

  ////////////////////////////////////////////////////////////
  // Forwarding FSM
  ////////////////////////////////////////////////////////////

  // A flit leaves when the granted input has one and the link is free
  assign fwd  = (state_q != reserve_port) & sel_valid & ~stop_i;
  assign rd_o = fwd ? gnt_q : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      reserve_port: begin
        if (arb_valid && !stop_i) begin
          state_d = head_flit;
        end
      end
      head_flit: begin
        // Single-flit packets go straight back to arbitration
        if (fwd) begin
          state_d = sel_flit.tail ? reserve_port : payload_flits;
        end
      end
      payload_flits: begin
        if (fwd && sel_flit.tail) begin
          state_d = reserve_port;
        end
      end
      default: state_d = reserve_port;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= reserve_port;
      gnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Capture the winner for the whole worm
      if (state_q == reserve_port && arb_valid && !stop_i) begin
        gnt_q <= grant_full;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  // Flit and void hold while the receiver stops us
  always_ff @(posedge clk) begin
    if (fwd) begin
      flit_q <= out_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      void_q <= 1'b1;
    end else if (fwd) begin
      void_q <= 1'b0;
    end else if (!stop_i) begin
      void_q <= 1'b1;
    end
  end

  assign flit_o = flit_q;
  assign void_o = void_q;

endmodule

//--- rtl/mesh_router.sv
// Five-port wormhole mesh router with XY look-ahead routing and ACK/NACK links
`timescale 1ns/1ps

module mesh_router import noc_pkg::*; #(
  parameter int FifoDepth = 4
) (
  input  logic       clk,
  input  logic       rst,
  // Router position on the mesh
  input  xy_t        position_i,
  // Input links
  input  flit_t      flit_n_i,
  input  flit_t      flit_s_i,
  input  flit_t      flit_w_i,
  input  flit_t      flit_e_i,
  input  flit_t      flit_p_i,
  input  logic [4:0] void_i,
  output logic [4:0] stop_o,
  // Output links
  output flit_t      flit_n_o,
  output flit_t      flit_s_o,
  output flit_t      flit_w_o,
  output flit_t      flit_e_o,
  output flit_t      flit_p_o,
  output logic [4:0] void_o,
  input  logic [4:0] stop_i
);

  flit_t [num_ports-1:0]                  in_flit;
  flit_t [num_ports-1:0]                  heads;
  logic  [num_ports-1:0]                  valids;
  dir_t  [num_ports-1:0]                  reqs;
  flit_t [num_ports-1:0]                  out_flit;
  // Read matrix, first index is the output, second the input
  logic  [num_ports-1:0][num_ports-1:0]   rd;
  logic  [num_ports-1:0]                  rd_in;

  ////////////////////////////////////////////////////////////
  // Link packing
  ////////////////////////////////////////////////////////////

  assign in_flit[north_port] = flit_n_i;
  assign in_flit[south_port] = flit_s_i;
  assign in_flit[west_port]  = flit_w_i;
  assign in_flit[east_port]  = flit_e_i;
  assign in_flit[local_port] = flit_p_i;

  assign flit_n_o = out_flit[north_port];
  assign flit_s_o = out_flit[south_port];
  assign flit_w_o = out_flit[west_port];
  assign flit_e_o = out_flit[east_port];
  assign flit_p_o = out_flit[local_port];

  // An input is popped when any output reads it
  always_comb begin
    rd_in = '0;
    for (int o = 0; o < num_ports; o++) begin
      rd_in = rd_in | rd[o];
    end
  end

  ////////////////////////////////////////////////////////////
  // Input and output units
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < num_ports; g++) begin : gen_in
    input_port #(
      .FifoDepth(FifoDepth)
    ) u_in (
      .clk    (clk),
      .rst    (rst),
      .flit_i (in_flit[g]),
      .void_i (void_i[g]),
      .stop_o (stop_o[g]),
      .rd_i   (rd_in[g]),
      .head_o (heads[g]),
      .valid_o(valids[g]),
      .req_o  (reqs[g])
    );
  end

  for (genvar g = 0; g < num_ports; g++) begin : gen_out
    // Each output knows its own direction
    output_port #(
      .OutDir(port_idx_t'(g))
    ) u_out (
      .clk       (clk),
      .rst       (rst),
      .position_i(position_i),
      .heads_i   (heads),
      .valids_i  (valids),
      .reqs_i    (reqs),
      .rd_o      (rd[g]),
      .stop_i    (stop_i[g]),
      .flit_o    (out_flit[g]),
      .void_o    (void_o[g])
    );
  end

endmodule

//--- tests/router_assertions.sv
// Protocol checks on the mesh router output links and crossbar read strobes
`timescale 1ns/1ps

module router_assertions import noc_pkg::*; (
  input logic                                 clk,
  input logic                                 rst,
  input logic  [num_ports-1:0]                link_void_i,
  input logic  [num_ports-1:0]                link_stop_i,
  input flit_t [num_ports-1:0]                link_flit_i,
  input logic  [num_ports-1:0]                valid_i,
  input logic  [num_ports-1:0][num_ports-1:0] rd_i,
  input logic  [num_ports-1:0]                rd_in_i
);

  // Every output void right after reset
  a_void_after_reset: assert property (@(posedge clk) $past(rst) |-> (link_void_i == '1))
    else $error("void_o not all high after reset");

  // Inputs popped only while their front is a real flit
  a_read_valid: assert property (@(posedge clk) disable iff (rst) (rd_in_i & ~valid_i) == '0)
    else $error("input read while not valid");

  for (genvar o = 0; o < num_ports; o++) begin : gen_link
    // A new flit on the link needs a read in the cycle before
    a_flit_needs_read: assert property (@(posedge clk) disable iff (rst)
      (!link_void_i[o] && !$past(link_stop_i[o])) |-> $past(|rd_i[o]))
      else $error("output %0d left void without reading an input", o);

    // NACK holds flit and void
    a_hold_on_stop: assert property (@(posedge clk) disable iff (rst)
      ($past(link_stop_i[o]) && !$past(rst)) |->
      ($stable(link_void_i[o]) && $stable(link_flit_i[o])))
      else $error("output %0d changed while stopped", o);

    // At most one input read per output
    a_rd_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(rd_i[o]))
      else $error("output %0d reads more than one input", o);
  end

endmodule

bind mesh_router router_assertions u_router_assertions (
  .clk        (clk),
  .rst        (rst),
  .link_void_i(void_o),
  .link_stop_i(stop_i),
  .link_flit_i(out_flit),
  .valid_i    (valids),
  .rd_i       (rd),
  .rd_in_i    (rd_in)
);

//--- tests/tb_mesh_router.sv
// Self-checking testbench for the five-port mesh router with one scoreboard per link
`timescale 1ns/1ps

module tb_mesh_router import noc_pkg::*; ();

  // Router under test sits in the middle of the mesh
  localparam xy_t here_pos = {3'd3, 3'd3};

  logic                  clk;
  logic                  rst;
  flit_t [num_ports-1:0] in_flit;
  logic  [4:0]           void_in;
  logic  [4:0]           stop_out;
  flit_t [num_ports-1:0] out_flit;
  logic  [4:0]           void_out;
  logic  [4:0]           stop_in;

  // Pending flits per input and expected flits per output and input pair
  flit_t       send_q [num_ports][$];
  flit_t       exp_q  [num_ports*num_ports][$];
  logic  [4:0] sent_last;
  logic  [4:0] stop_force;
  logic        rand_stop;
  logic  [4:0] in_worm;
  int          cur_src [num_ports];
  logic [31:0] lfsr_state;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          flits_sent;
  int          flits_recv;
  int          cycle;

  mesh_router #(
    .FifoDepth(4)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .position_i(here_pos),
    .flit_n_i  (in_flit[north_port]),
    .flit_s_i  (in_flit[south_port]),
    .flit_w_i  (in_flit[west_port]),
    .flit_e_i  (in_flit[east_port]),
    .flit_p_i  (in_flit[local_port]),
    .void_i    (void_in),
    .stop_o    (stop_out),
    .flit_n_o  (out_flit[north_port]),
    .flit_s_o  (out_flit[south_port]),
    .flit_w_o  (out_flit[west_port]),
    .flit_e_o  (out_flit[east_port]),
    .flit_p_o  (out_flit[local_port]),
    .void_o    (void_out),
    .stop_i    (stop_in)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random numbers and reference routing
  ////////////////////////////////////////////////////////////

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Dimension order routes X before Y
  function automatic int xy_port(xy_t pos, xy_t dst);
    int port;
    if (dst.x > pos.x) begin
      port = int'(east_port);
    end else if (dst.x < pos.x) begin
      port = int'(west_port);
    end else if (dst.y > pos.y) begin
      port = int'(south_port);
    end else if (dst.y < pos.y) begin
      port = int'(north_port);
    end else begin
      port = int'(local_port);
    end
    return port;
  endfunction

  // Output port here and the routing field expected at the neighbour
  function automatic dir_t ref_route(input xy_t dst, output int out_port);
    xy_t nbr;
    out_port = xy_port(here_pos, dst);
    nbr = here_pos;
    case (out_port)
      0:       nbr.y = here_pos.y - 3'd1;
      1:       nbr.y = here_pos.y + 3'd1;
      2:       nbr.x = here_pos.x - 3'd1;
      3:       nbr.x = here_pos.x + 3'd1;
      default: nbr = here_pos;
    endcase
    return dir_t'(1) << xy_port(nbr, dst);
  endfunction

  function automatic string link_name(int o);
    case (o)
      0:       return "flit_n_o";
      1:       return "flit_s_o";
      2:       return "flit_w_o";
      3:       return "flit_e_o";
      default: return "flit_p_o";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Queue one worm with body flits tagged by the input index
  task automatic send_packet(input int src, input xy_t dst, input int len);
    header_t     hdr;
    flit_t       f;
    dir_t        exp_route;
    int          out;
    logic [31:0] r;
    exp_route = ref_route(dst, out);
    rand_bits(6, r);
    hdr.source      = r[5:0];
    hdr.destination = dst;
    hdr.message     = msg_t'(src);
    rand_bits(hdr_pad_w, r);
    hdr.pad         = r[hdr_pad_w-1:0];
    hdr.routing     = dir_t'(1) << xy_port(here_pos, dst);
    f.head = 1'b1;
    f.tail = (len == 1);
    f.body = hdr;
    send_q[src].push_back(f);
    // Head leaves with the look-ahead field
    hdr.routing = exp_route;
    f.body = hdr;
    exp_q[out*num_ports+src].push_back(f);
    for (int k = 1; k < len; k++) begin
      rand_bits(28, r);
      f.head = 1'b0;
      f.tail = (k == len - 1);
      f.body = {4'(src), r[27:0]};
      send_q[src].push_back(f);
      exp_q[out*num_ports+src].push_back(f);
    end
    flits_sent += len;
  endtask

  // Senders and link stops
  // stop_o reacts one transfer late, so a sender idles one cycle after each flit
  always @(posedge clk) begin : drive_links
    logic [31:0] r;
    if (rst) begin
      void_in   <= '1;
      stop_in   <= '0;
      sent_last = '0;
    end else begin
      for (int i = 0; i < num_ports; i++) begin
        if (send_q[i].size() > 0 && !stop_out[i] && !sent_last[i]) begin
          in_flit[i]   <= send_q[i].pop_front();
          void_in[i]   <= 1'b0;
          sent_last[i] = 1'b1;
        end else begin
          void_in[i]   <= 1'b1;
          sent_last[i] = 1'b0;
        end
        rand_bits(2, r);
        stop_in[i] <= stop_force[i] | (rand_stop & (r[1:0] == 2'b11));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////

  // A flit is taken on an edge with void low and our stop low
  always @(posedge clk) begin : compare_outputs
    flit_t   got;
    flit_t   exp;
    header_t hdr;
    int      q;
    if (!rst) begin
      for (int o = 0; o < num_ports; o++) begin
        if (!void_out[o] && !stop_in[o]) begin
          got = out_flit[o];
          flits_recv++;
          if (got.head) begin
            hdr = got.body;
            if (in_worm[o]) begin
              $display("** Error: new head on %s before the previous worm ended", link_name(o));
              errors++;
            end
            cur_src[o] = int'(hdr.message[2:0]);
            in_worm[o] = !got.tail;
          end else begin
            if (!in_worm[o]) begin
              $display("** Error: body flit on %s outside any worm", link_name(o));
              errors++;
            end
            if (got.tail) begin
              in_worm[o] = 1'b0;
            end
          end
          q = o * num_ports + cur_src[o];
          if (q >= num_ports * num_ports || exp_q[q].size() == 0) begin
            $display("** Error: unexpected flit 0x%h on %s", got, link_name(o));
            errors++;
          end else begin
            exp = exp_q[q].pop_front();
            check_value(link_name(o), got, exp);
          end
        end
      end
    end
  end

  // Limit grows with the traffic queued so far
  always @(posedge clk) begin : watchdog
    cycle++;
    if (cycle > flits_sent * 8 + 200) begin
      $display("Timeout after %0d cycles, %0d of %0d flits received", cycle, flits_recv,
               flits_sent);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  task automatic wait_drain();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int i = 0; i < num_ports; i++) begin
        if (send_q[i].size() > 0) begin
          busy = 1'b1;
        end
      end
      for (int q = 0; q < num_ports * num_ports; q++) begin
        if (exp_q[q].size() > 0) begin
          busy = 1'b1;
        end
      end
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("Test %0d %s: FAILED, %0d errors", tests_run, name, errors - err_before);
    end else begin
      $display("Test %0d %s: ok", tests_run, name);
    end
  endtask

  initial begin
    int          e;
    int          src;
    int          len;
    xy_t         dst;
    logic [31:0] r;
    logic        seen;
    clk          = 1'b0;
    rst          <= 1'b1;
    in_flit      <= '0;
    void_in      <= '1;
    stop_in      <= '0;
    stop_force   = '0;
    rand_stop    = 1'b0;
    sent_last    = '0;
    in_worm      = '0;
    lfsr_state   = 32'h4689;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    flits_sent   = 0;
    flits_recv   = 0;
    cycle        = 0;
    for (int o = 0; o < num_ports; o++) begin
      cur_src[o] = 0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Idle links after reset
    e = errors;
    @(negedge clk);
    check_value("void_o", void_out, 5'h1f);
    check_value("stop_o", stop_out, 5'h00);
    finish_test("reset state", e);

    // One single-flit packet per direction plus a turn at the neighbour
    e = errors;
    send_packet(local_port, {3'd5, 3'd3}, 1);
    send_packet(local_port, {3'd1, 3'd3}, 1);
    send_packet(local_port, {3'd3, 3'd0}, 1);
    send_packet(local_port, {3'd3, 3'd6}, 1);
    send_packet(local_port, {3'd4, 3'd1}, 1);
    send_packet(west_port, {3'd3, 3'd3}, 1);
    wait_drain();
    finish_test("single-flit routing", e);

    e = errors;
    send_packet(north_port, {3'd3, 3'd7}, 4);
    send_packet(east_port, {3'd0, 3'd5}, 6);
    send_packet(south_port, {3'd6, 3'd0}, 3);
    send_packet(local_port, {3'd3, 3'd1}, 5);
    send_packet(north_port, {3'd3, 3'd3}, 2);
    wait_drain();
    finish_test("multi-flit worms", e);

    // Three worms to east and two to local at the same time
    e = errors;
    send_packet(west_port, {3'd7, 3'd2}, 6);
    send_packet(north_port, {3'd6, 3'd5}, 6);
    send_packet(local_port, {3'd5, 3'd3}, 4);
    send_packet(south_port, {3'd3, 3'd3}, 5);
    send_packet(east_port, {3'd3, 3'd3}, 3);
    wait_drain();
    finish_test("output contention", e);

    e = errors;
    rand_stop = 1'b1;
    for (int p = 0; p < 40; p++) begin
      rand_bits(6, r);
      dst = r[5:0];
      rand_bits(3, r);
      src = int'(r[2:0]) % num_ports;
      // No U-turn through the own port
      if (src == xy_port(here_pos, dst)) begin
        src = (src + 1) % num_ports;
      end
      rand_bits(2, r);
      len = int'(r[1:0]) + 1;
      send_packet(src, dst, len);
    end
    wait_drain();
    rand_stop = 1'b0;
    finish_test("random back-pressure", e);

    // East blocked until the local queue fills
    e = errors;
    stop_force = 5'b01000;
    send_packet(local_port, {3'd6, 3'd3}, 8);
    seen = 1'b0;
    for (int c = 0; c < 40 && !seen; c++) begin
      @(negedge clk);
      seen = stop_out[local_port];
    end
    check_value("stop_o[4]", seen, 1'b1);
    repeat (10) @(negedge clk);
    check_value("stop_o[4]", stop_out[local_port], 1'b1);
    check_value("void_o[3]", void_out[east_port], 1'b1);
    stop_force = '0;
    wait_drain();
    finish_test("held output", e);

    check_value("flits received", flits_recv, flits_sent);
    $display("Tests: %0d, failed: %0d, flits sent: %0d, received: %0d, errors: %0d",
             tests_run, tests_failed, flits_sent, flits_recv, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verilog.f
common/noc_pkg.sv
rtl/router_fifo.sv
input_unit/input_port.sv
output_unit/rr_arbiter.sv
output_unit/output_port.sv
rtl/mesh_router.sv
tests/router_assertions.sv
tests/tb_mesh_router.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mesh router testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_mesh_router \
  -f verilog.f -o tb_mesh_router > build.log 2>&1 \
  && ./obj_dir/tb_mesh_router > sim.log 2>&1 \
  && grep -q "All tests passed!" sim.log \
  && echo "Simulation PASS" \
  || { cat build.log sim.log 2>/dev/null; echo "Simulation FAIL"; exit 1; }
